//--- calculator.f
calc_pkg.sv
calc_control.sv
operand_entry.sv
int_unit.sv
frac_unit.sv
result_convert.sv
calculator_top.sv
calculator_props.sv
calculator_tb.sv

//--- Bender.yml
package:
  name: calculator

sources:
  - files:
      - calc_pkg.sv
      - calc_control.sv
      - operand_entry.sv
      - int_unit.sv
      - frac_unit.sv
      - result_convert.sv
      - calculator_top.sv
  - target: test
    files:
      - calculator_props.sv
      - calculator_tb.sv

//--- calculator_tb.sv
`timescale 1ns/100ps

module calculator_tb;
    import calc_pkg::*;

    localparam int INT_RUNS  = 20;
    localparam int FRAC_RUNS = 10;
    localparam int NUM_TESTS = 1 + 4 * INT_RUNS + 2 * FRAC_RUNS + 1;

    typedef struct packed {
        result_t raw;
        bcd_t    bcd;
    } model_t;

    logic        CLK100MHz;
    logic        rst;
    logic [15:0] sw;
    logic        btn_c;
    logic        btn_u;
    bcd_t        display;
    calc_state_t calc_state;

    integer seed       = 2186;
    int     err_count  = 0;
    int     test_count = 0;
    int     fail_count = 0;
    int     disp_cycles = 0;    // Cycles spent in ST_DISPLAY
    logic   check_req  = 1'b0;  // Raised by stimulus, cleared by the compare process
    logic   want_display;
    bcd_t   exp_display;
    string  check_name;

    calculator_top dut (
        .CLK100MHz  (CLK100MHz),
        .rst        (rst),
        .sw         (sw),
        .btn_c      (btn_c),
        .btn_u      (btn_u),
        .display    (display),
        .calc_state (calc_state)
    );

    always #5 CLK100MHz = ~CLK100MHz;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic model_t calc_model(input operand_t a, input operand_t b,
                                          input op_code_t op);
        model_t m;
        int     v;
        int     shown;
        case (op)
            OP_SUB:  v = (int'(a) - int'(b)) & 'hFFFF;
            OP_MUL:  v = int'(a) * int'(b);
            OP_POW: begin
                v = 1;
                for (int i = 0; i < int'(b) % 16; i++) begin
                    v = (v * int'(a)) & 'hFFFF;
                end
            end
            OP_DIV:  v = (b == 0) ? 'hFFFF : (int'(a) * 256) / int'(b);
            OP_SQRT: begin
                v = 0;
                while ((v + 1) * (v + 1) <= int'(a) * 65536) begin
                    v = v + 1;
                end
            end
            default: v = int'(a) + int'(b);
        endcase
        m.raw = result_t'(v);
        shown = (op == OP_DIV || op == OP_SQRT) ? v / 256 : v;  // Integer part of Q8.8
        for (int i = 0; i < 5; i++) begin
            m.bcd[4*i +: 4] = 4'(shown % 10);
            shown = shown / 10;
        end
        return m;
    endfunction

    // Compare process
    always @(negedge CLK100MHz) begin
        disp_cycles = (calc_state == ST_DISPLAY) ? disp_cycles + 1 : 0;
        if (check_req && (!want_display || disp_cycles >= 2)) begin
            if (display !== exp_display) begin
                $display("Mismatch at %0t ns: %s shows %h, expected %h",
                         $time, check_name, display, exp_display);
                err_count = err_count + 1;
            end
            check_req = 1'b0;
        end
    end

    task automatic press_button(input logic up);
        @(posedge CLK100MHz);
        if (up) begin
            btn_u <= 1'b1;
        end else begin
            btn_c <= 1'b1;
        end
        repeat (2) @(posedge CLK100MHz);
        btn_u <= 1'b0;
        btn_c <= 1'b0;
        repeat (2) @(posedge CLK100MHz);
    endtask

    task automatic expect_display(input bcd_t value, input string what, input logic in_display);
        exp_display  = value;
        check_name   = what;
        want_display = in_display;
        check_req    = 1'b1;
        wait (!check_req);
    endtask

    task automatic report_test(input string what, input int errs_before);
        test_count = test_count + 1;
        if (err_count == errs_before) begin
            $display("Test %0d %s: pass", test_count, what);
        end else begin
            fail_count = fail_count + 1;
            $display("Test %0d %s: FAIL", test_count, what);
        end
    endtask

    task automatic run_calc(input operand_t a, input operand_t b, input op_code_t op);
        model_t exp;
        int     errs_before;
        exp         = calc_model(a, b, op);
        errs_before = err_count;
        @(posedge CLK100MHz);
        sw <= {b, a};
        press_button(1'b0);
        expect_display({4'd0, b, a}, "entry operands", 1'b0);
        @(posedge CLK100MHz);
        sw <= {13'd0, op};
        press_button(1'b0);
        press_button(1'b0);  // Third press starts both units
        expect_display(exp.bcd, "mode 0 digits", 1'b1);
        press_button(1'b1);
        expect_display({4'd0, exp.raw}, "mode 1 raw", 1'b1);
        press_button(1'b1);
        expect_display({4'd0, b, a}, "mode 2 operands", 1'b1);
        press_button(1'b1);
        expect_display({17'd0, op}, "mode 3 op code", 1'b1);
        press_button(1'b1);
        expect_display(exp.bcd, "mode wrap to 0", 1'b1);
        press_button(1'b0);
        if (calc_state != ST_ENTRY) begin
            $display("Error at %0t ns: centre press in display did not return to entry", $time);
            err_count = err_count + 1;
        end
        report_test($sformatf("%s a=%0d b=%0d", op.name(), a, b), errs_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        operand_t a;
        operand_t b;
        int       errs;
        CLK100MHz = 1'b0;
        rst       = 1'b1;
        sw        = '0;
        btn_c     = 1'b0;
        btn_u     = 1'b0;
        repeat (3) @(posedge CLK100MHz);
        rst <= 1'b0;
        repeat (2) @(posedge CLK100MHz);
        errs = err_count;
        expect_display('0, "reset display", 1'b0);
        if (calc_state != ST_ENTRY) begin
            $display("Error at %0t ns: state machine did not reach entry after reset", $time);
            err_count = err_count + 1;
        end
        report_test("reset", errs);
        for (int k = 0; k < 4 * INT_RUNS; k++) begin
            a = operand_t'($random(seed));
            b = operand_t'($random(seed));
            run_calc(a, b, op_code_t'(3'(k / INT_RUNS)));
        end
        for (int k = 0; k < 2 * FRAC_RUNS; k++) begin
            a = operand_t'($random(seed));
            b = operand_t'($random(seed));
            run_calc(a, b, (k < FRAC_RUNS) ? OP_DIV : OP_SQRT);
        end
        a = operand_t'($random(seed));
        run_calc(a, 8'd0, OP_DIV);  // Divide by zero
        $display("%0d tests run, %0d passed, %0d failed", test_count,
                 test_count - fail_count, fail_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_TESTS * 200 + 100) * 10);
        $display("Timeout: the run did not finish within %0d cycles", NUM_TESTS * 200 + 100);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- calculator_props.sv
`timescale 1ns/100ps

module calc_control_props (
    input logic                  CLK100MHz,
    input logic                  rst,
    input logic                  capture_operands,
    input logic                  capture_op,
    input logic                  start,
    input logic                  convert_en,
    input logic                  conversion_ready,
    input calc_pkg::disp_mode_t  disp_mode,
    input calc_pkg::calc_state_t calc_state
);
    import calc_pkg::*;

    start_single_pulse: assert property (@(posedge CLK100MHz) disable iff (rst)
        start |=> !start)
        else $error("start stayed high for more than one cycle");

    convert_en_held: assert property (@(posedge CLK100MHz) disable iff (rst)
        convert_en && !conversion_ready |=> convert_en)
        else $error("convert_en dropped before conversion_ready");

    reset_values: assert property (@(posedge CLK100MHz)
        rst |=> (calc_state == ST_INIT) && !start && !capture_operands && !capture_op
                && !convert_en && (disp_mode == '0))
        else $error("state machine not idle after reset");

endmodule

bind calc_control calc_control_props u_props (
    .CLK100MHz        (CLK100MHz),
    .rst              (rst),
    .capture_operands (capture_operands),
    .capture_op       (capture_op),
    .start            (start),
    .convert_en       (convert_en),
    .conversion_ready (conversion_ready),
    .disp_mode        (disp_mode),
    .calc_state       (calc_state)
);

//--- calculator_top.sv
`timescale 1ns/100ps

module calculator_top (
    input  logic                  CLK100MHz,
    input  logic                  rst,
    input  logic [15:0]           sw,
    input  logic                  btn_c,
    input  logic                  btn_u,
    output calc_pkg::bcd_t        display,
    output calc_pkg::calc_state_t calc_state
);
    import calc_pkg::*;

    logic          capture_operands;
    logic          capture_op;
    logic          start;
    logic          convert_en;
    logic          result_ready;
    logic          conversion_ready;
    disp_mode_t    disp_mode;
    calc_request_t request;
    unit_result_t  int_result;
    unit_result_t  frac_result;

    calc_control u_control (
        .CLK100MHz        (CLK100MHz),
        .rst              (rst),
        .btn_c            (btn_c),
        .btn_u            (btn_u),
        .result_ready     (result_ready),
        .conversion_ready (conversion_ready),
        .capture_operands (capture_operands),
        .capture_op       (capture_op),
        .start            (start),
        .convert_en       (convert_en),
        .disp_mode        (disp_mode),
        .calc_state       (calc_state)
    );

    operand_entry u_entry (
        .CLK100MHz        (CLK100MHz),
        .rst              (rst),
        .sw               (sw),
        .capture_operands (capture_operands),
        .capture_op       (capture_op),
        .request          (request)
    );

    // Both units see the same start pulse
    int_unit u_int (
        .CLK100MHz (CLK100MHz),
        .rst       (rst),
        .start     (start),
        .request   (request),
        .result    (int_result)
    );

    frac_unit u_frac (
        .CLK100MHz (CLK100MHz),
        .rst       (rst),
        .start     (start),
        .request   (request),
        .result    (frac_result)
    );

    result_convert u_convert (
        .CLK100MHz        (CLK100MHz),
        .rst              (rst),
        .request          (request),
        .int_result       (int_result),
        .frac_result      (frac_result),
        .convert_en       (convert_en),
        .disp_mode        (disp_mode),
        .calc_state       (calc_state),
        .result_ready     (result_ready),
        .conversion_ready (conversion_ready),
        .display          (display)
    );

endmodule

//--- result_convert.sv
`timescale 1ns/100ps

module result_convert (
    input  logic                    CLK100MHz,
    input  logic                    rst,
    input  calc_pkg::calc_request_t request,
    input  calc_pkg::unit_result_t  int_result,
    input  calc_pkg::unit_result_t  frac_result,
    input  logic                    convert_en,
    input  calc_pkg::disp_mode_t    disp_mode,
    input  calc_pkg::calc_state_t   calc_state,
    output logic                    result_ready,
    output logic                    conversion_ready,
    output calc_pkg::bcd_t          display
);
    import calc_pkg::*;

    unit_result_t picked;
    result_t      held;
    logic         conv_en_q;
    logic         conv_start;
    logic         conv_busy;
    logic [4:0]   conv_cnt;
    result_t      bin_sr;
    bcd_t         bcd_sr;
    bcd_t         bcd_adj;

    assign picked     = (request.kind == KIND_FRAC) ? frac_result : int_result;
    assign conv_start = convert_en && !conv_en_q;

    always_ff @(posedge CLK100MHz) begin
        if (picked.valid) begin
            held <= picked.value;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Double dabble, one input bit per cycle
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        bcd_adj = bcd_sr;
        for (int i = 0; i < BCD_W / 4; i++) begin
            if (bcd_sr[4*i +: 4] > 4'd4) begin
                bcd_adj[4*i +: 4] = bcd_sr[4*i +: 4] + 4'd3;
            end
        end
    end

    always_ff @(posedge CLK100MHz) begin
        if (rst) begin
            result_ready     <= 1'b0;
            conversion_ready <= 1'b0;
            conv_en_q        <= 1'b0;
            conv_busy        <= 1'b0;
            conv_cnt         <= '0;
        end else begin
            result_ready     <= picked.valid;
            conversion_ready <= 1'b0;
            conv_en_q        <= convert_en;
            if (conv_start) begin
                conv_busy <= 1'b1;
                conv_cnt  <= 5'(RESULT_W);
            end else if (conv_busy) begin
                conv_cnt <= conv_cnt - 5'd1;
                if (conv_cnt == 5'd1) begin
                    conv_busy        <= 1'b0;
                    conversion_ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK100MHz) begin
        if (conv_start) begin
            // Frac results show their integer byte only
            bin_sr <= (request.kind == KIND_FRAC) ? {8'd0, held[RESULT_W-1:FRAC_BITS]} : held;
            bcd_sr <= '0;
        end else if (conv_busy) begin
            bcd_sr <= {bcd_adj[BCD_W-2:0], bin_sr[RESULT_W-1]};
            bin_sr <= {bin_sr[RESULT_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge CLK100MHz) begin
        if (rst) begin
            display <= '0;
        end else if (calc_state == ST_DISPLAY) begin
            case (disp_mode)
                2'd0:    display <= bcd_sr;
                2'd1:    display <= {4'd0, held};
                2'd2:    display <= {4'd0, request.b, request.a};
                default: display <= {17'd0, request.op};
            endcase
        end else begin
            display <= {4'd0, request.b, request.a};  // Operands while entering
        end
    end

endmodule

//--- frac_unit.sv
`timescale 1ns/100ps

module frac_unit (
    input  logic                    CLK100MHz,
    input  logic                    rst,
    input  logic                    start,
    input  calc_pkg::calc_request_t request,
    output calc_pkg::unit_result_t  result
);
    import calc_pkg::*;

    logic        busy;
    logic        valid;
    logic        is_sqrt;
    logic [4:0]  iter_cnt;
    logic [23:0] work;       // Dividend or radicand, consumed from the top
    logic [14:0] rem;
    result_t     quot;       // Quotient or root
    logic [14:0] trial_in;
    logic [14:0] trial_sub;
    logic        fits;

    ////////////////////////////////////////////////////////////////////////////
    // One restoring step, shared by divide and square root
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        if (is_sqrt) begin
            trial_in  = {rem[12:0], work[23:22]};   // Two radicand bits per step
            trial_sub = {1'b0, quot[11:0], 2'b01};  // 4 * root + 1
        end else begin
            trial_in  = {rem[13:0], work[23]};
            trial_sub = {7'd0, request.b};          // b = 0 gives all ones
        end
        fits = (trial_in >= trial_sub);
    end

    always_ff @(posedge CLK100MHz) begin
        if (rst) begin
            busy     <= 1'b0;
            valid    <= 1'b0;
            is_sqrt  <= 1'b0;
            iter_cnt <= '0;
        end else begin
            valid <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                is_sqrt  <= (request.op == OP_SQRT);
                iter_cnt <= (request.op == OP_SQRT) ? 5'((OPERAND_W + 2 * FRAC_BITS) / 2)
                                                    : 5'(RESULT_W);
            end else if (busy) begin
                iter_cnt <= iter_cnt - 5'd1;
                if (iter_cnt == 5'd1) begin
                    busy  <= 1'b0;
                    valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK100MHz) begin
        if (start) begin
            work <= {request.a, {2 * FRAC_BITS{1'b0}}};  // a * 256 or a * 65536
            rem  <= '0;
            quot <= '0;
        end else if (busy) begin
            work <= is_sqrt ? {work[21:0], 2'b00} : {work[22:0], 1'b0};
            rem  <= fits ? trial_in - trial_sub : trial_in;
            quot <= {quot[14:0], fits};
        end
    end

    assign result.value = quot;
    assign result.valid = valid;

endmodule

//--- int_unit.sv
`timescale 1ns/100ps

module int_unit (
    input  logic                    CLK100MHz,
    input  logic                    rst,
    input  logic                    start,
    input  calc_pkg::calc_request_t request,
    output calc_pkg::unit_result_t  result
);
    import calc_pkg::*;

    logic       busy;
    logic       valid;
    logic [3:0] exponent;
    logic [3:0] pow_cnt;   // Multiplies left
    result_t    direct;
    result_t    acc;

    assign exponent = request.b[3:0];

    always_comb begin
        case (request.op)
            OP_SUB:  direct = request.a - request.b;  // Wraps mod 2^16
            OP_MUL:  direct = request.a * request.b;
            default: direct = request.a + request.b;  // Frac ops land here too
        endcase
    end

    always_ff @(posedge CLK100MHz) begin
        if (rst) begin
            busy    <= 1'b0;
            valid   <= 1'b0;
            pow_cnt <= '0;
        end else begin
            valid <= 1'b0;
            if (start) begin
                pow_cnt <= exponent;
                busy    <= (request.op == OP_POW) && (exponent != 4'd0);
                valid   <= (request.op != OP_POW) || (exponent == 4'd0);
            end else if (busy) begin
                pow_cnt <= pow_cnt - 4'd1;
                if (pow_cnt == 4'd1) begin
                    busy  <= 1'b0;
                    valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK100MHz) begin
        if (start) begin
            acc <= (request.op == OP_POW) ? result_t'(1) : direct;
        end else if (busy) begin
            acc <= acc * request.a;  // Truncated to 16 bits
        end
    end

    assign result.value = acc;
    assign result.valid = valid;

endmodule

//--- operand_entry.sv
`timescale 1ns/100ps

module operand_entry (
    input  logic                    CLK100MHz,
    input  logic                    rst,
    input  logic [15:0]             sw,
    input  logic                    capture_operands,
    input  logic                    capture_op,
    output calc_pkg::calc_request_t request
);
    import calc_pkg::*;

    op_code_t sw_op;

    // Codes 6 and 7 fall back to add
    assign sw_op = (sw[2:0] > 3'd5) ? OP_ADD : op_code_t'(sw[2:0]);

    always_ff @(posedge CLK100MHz) begin
        if (rst) begin
            request <= '0;
        end else begin
            if (capture_operands) begin
                request.a <= sw[OPERAND_W-1:0];
                request.b <= sw[2*OPERAND_W-1:OPERAND_W];
            end
            if (capture_op) begin
                request.op   <= sw_op;
                request.kind <= (sw_op == OP_DIV || sw_op == OP_SQRT) ? KIND_FRAC : KIND_INT;
            end
        end
    end

endmodule

//--- calc_control.sv
`timescale 1ns/100ps

module calc_control (
    input  logic                  CLK100MHz,
    input  logic                  rst,
    input  logic                  btn_c,
    input  logic                  btn_u,
    input  logic                  result_ready,
    input  logic                  conversion_ready,
    output logic                  capture_operands,
    output logic                  capture_op,
    output logic                  start,
    output logic                  convert_en,
    output calc_pkg::disp_mode_t  disp_mode,
    output calc_pkg::calc_state_t calc_state
);
    import calc_pkg::*;

    logic       btn_c_q;
    logic       btn_u_q;
    logic       c_edge;
    logic       u_edge;
    logic [1:0] press_cnt;  // Centre presses seen in entry

    assign c_edge = btn_c && !btn_c_q;
    assign u_edge = btn_u && !btn_u_q;

    always_ff @(posedge CLK100MHz) begin
        if (rst) begin
            calc_state       <= ST_INIT;
            capture_operands <= 1'b0;
            capture_op       <= 1'b0;
            start            <= 1'b0;
            convert_en       <= 1'b0;
            disp_mode        <= '0;
            press_cnt        <= '0;
            btn_c_q          <= 1'b0;
            btn_u_q          <= 1'b0;
        end else begin
            btn_c_q          <= btn_c;
            btn_u_q          <= btn_u;
            capture_operands <= 1'b0;  // Strobes default low
            capture_op       <= 1'b0;
            start            <= 1'b0;
            case (calc_state)
                ST_INIT: begin
                    press_cnt  <= '0;
                    disp_mode  <= '0;
                    convert_en <= 1'b0;
                    calc_state <= ST_ENTRY;
                end
                ST_ENTRY: begin
                    if (c_edge) begin
                        if (press_cnt == 2'(ENTRY_PRESSES - 1)) begin
                            start      <= 1'b1;
                            press_cnt  <= '0;
                            calc_state <= ST_ARITH;
                        end else begin
                            capture_operands <= (press_cnt == 2'd0);
                            capture_op       <= (press_cnt == 2'd1);
                            press_cnt        <= press_cnt + 2'd1;
                        end
                    end
                end
                ST_ARITH: begin
                    if (result_ready) begin
                        convert_en <= 1'b1;  // Held until BCD done
                        calc_state <= ST_CONVERT;
                    end
                end
                ST_CONVERT: begin
                    if (conversion_ready) begin
                        convert_en <= 1'b0;
                        calc_state <= ST_DISPLAY;
                    end
                end
                ST_DISPLAY: begin
                    if (c_edge) begin
                        calc_state <= ST_INIT;
                    end else if (u_edge) begin
                        disp_mode <= disp_mode + 2'd1;  // Wraps 3 -> 0
                    end
                end
                default: begin
                    calc_state <= ST_INIT;
                end
            endcase
        end
    end

endmodule

//--- calc_pkg.sv
package calc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int OPERAND_W     = 8;
    localparam int RESULT_W      = 16;
    localparam int BCD_W         = 20;  // Five digits
    localparam int FRAC_BITS     = 8;   // Q8.8
    localparam int ENTRY_PRESSES = 3;

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [RESULT_W-1:0]  result_t;
    typedef logic [BCD_W-1:0]     bcd_t;
    typedef logic [1:0]           disp_mode_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_MUL  = 3'd2,
        OP_POW  = 3'd3,
        OP_DIV  = 3'd4,
        OP_SQRT = 3'd5
    } op_code_t;

    typedef enum logic {
        KIND_INT  = 1'b0,
        KIND_FRAC = 1'b1
    } result_kind_t;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_ENTRY,
        ST_ARITH,
        ST_CONVERT,
        ST_DISPLAY
    } calc_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles between blocks
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        operand_t     a;
        operand_t     b;
        op_code_t     op;
        result_kind_t kind;
    } calc_request_t;

    typedef struct packed {
        result_t value;
        logic    valid;  // One-cycle done pulse
    } unit_result_t;

endpackage
